/* build.f */
hdl/adc_pkg.sv
hdl/spi_frame_timer.sv
hdl/adc_spi_capture.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/readout_controller.sv
hdl/adc_uart_top.sv
tb/adc_uart_properties.sv
tb/tb_adc_uart_top.sv

/* run.sh */
#!/bin/sh
# Build the simulation with Verilator, run it and look for the pass message.
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_adc_uart_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "TB PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

/* tb/tb_adc_uart_top.sv */
// Testbench with clock, reset, ADC and host UART models and the directed readout tests.
module tb_adc_uart_top import adc_pkg::*;;

    logic                    clk;
    logic                    reset_b;
    logic [num_channels-1:0] adc_sdata;
    logic                    cs;
    logic                    sclk;
    logic                    rx;
    logic                    tx;
    sample_t                 adc_value [num_channels];
    int                      bit_ptr;
    logic                    cs_q;
    logic                    sclk_q;
    int                      check_errors;
    int                      timeout_errors;
    integer                  seed;

    adc_uart_top i_adc_uart_top (
        .clk       (clk),
        .reset_b   (reset_b),
        .adc_sdata (adc_sdata),
        .cs        (cs),
        .sclk      (sclk),
        .rx        (rx),
        .tx        (tx)
    );

    always #4 clk = ~clk;

    // ADC frame is 4 zeros, the value MSB first and 2 trailing zeros.
    function automatic logic frame_bit(input sample_t value, input int ptr);
        logic [15:0] word;
        word = {4'b0000, value, 2'b00};
        if (ptr > 15) return 1'b0;
        return word[15 - ptr];
    endfunction

    // all four ADCs restart on cs falling and advance after each sclk falling edge.
    always @(negedge clk) begin
        if (cs_q && !cs) begin
            bit_ptr = 0;
        end else if (sclk_q && !sclk && !cs) begin
            bit_ptr = bit_ptr + 1;
        end
        for (int ch = 0; ch < num_channels; ch++) begin
            adc_sdata[ch] <= frame_bit(adc_value[ch], bit_ptr);
        end
        cs_q = cs;
        sclk_q = sclk;
    end

    task automatic send_byte(input logic [7:0] data);
        logic [9:0] bits;
        bits = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = bits[i];
            repeat (clks_per_bit) @(negedge clk);
        end
    endtask

    task automatic expect_byte(input string name, input logic [7:0] expected, input int limit);
        logic [7:0] data;
        int         n;
        n = 0;
        data = '0;
        while (tx === 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (n >= limit) begin
            $display("timeout: no start bit on tx within %0d cycles for %s", limit, name);
            timeout_errors++;
            return;
        end
        // move to the middle of the start bit, then step one bit period at a time.
        repeat (clks_per_bit / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (tx !== 1'b1) begin
            $display("CHECK FAILED tx stop bit of %s expected 0x1 actual 0x%0h", name, tx);
            check_errors++;
        end
        if (data !== expected) begin
            $display("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, expected, data);
            check_errors++;
        end
    endtask

    task automatic expect_silence(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                $display("an unexpected byte started on tx");
                check_errors++;
                return;
            end
        end
    endtask

    task automatic wait_frames(input int frames);
        int n;
        for (int f = 0; f < frames; f++) begin
            n = 0;
            while (cs !== 1'b0 && n < 300) begin
                @(negedge clk);
                n++;
            end
            while (cs !== 1'b1 && n < 300) begin
                @(negedge clk);
                n++;
            end
            if (n >= 300) begin
                $display("timeout: the SPI frame did not complete within 300 cycles");
                timeout_errors++;
                return;
            end
        end
        @(negedge clk);
    endtask

    task automatic read_channel(input logic [1:0] ch, input sample_t value);
        fork
            send_byte(cmd_read_base + 8'(ch));
            begin
                expect_byte("tx high byte", {ch, 4'b0000, value[9:8]}, 400);
                expect_byte("tx low byte", value[7:0], 100);
            end
        join
    endtask

    task automatic verify_reset_state();
        if (tx !== 1'b1) begin
            $display("CHECK FAILED tx expected 0x1 actual 0x%0h", tx);
            check_errors++;
        end
        if (cs !== 1'b1) begin
            $display("CHECK FAILED cs expected 0x1 actual 0x%0h", cs);
            check_errors++;
        end
        if (sclk !== 1'b0) begin
            $display("CHECK FAILED sclk expected 0x0 actual 0x%0h", sclk);
            check_errors++;
        end
        expect_silence(500);
    endtask

    task automatic read_all_channels(input sample_t v0, input sample_t v1,
                                     input sample_t v2, input sample_t v3);
        adc_value[0] = v0;
        adc_value[1] = v1;
        adc_value[2] = v2;
        adc_value[3] = v3;
        wait_frames(2);
        for (int ch = 0; ch < num_channels; ch++) begin
            read_channel(2'(ch), adc_value[ch]);
        end
    endtask

    task automatic reject_bad_commands();
        logic [7:0] cmds [3];
        cmds = '{8'h00, 8'h45, 8'h61};
        foreach (cmds[i]) begin
            fork
                send_byte(cmds[i]);
                expect_byte("tx error byte", 8'h3f, 400);
            join
            expect_silence(200);
        end
    endtask

    task automatic random_channel_reads();
        logic [1:0] ch;
        sample_t    value;
        for (int round = 0; round < 20; round++) begin
            ch = 2'($random(seed));
            value = 10'($random(seed));
            adc_value[ch] = value;
            wait_frames(2);
            read_channel(ch, value);
        end
    endtask

    // the second command lands while the reply is going out and must be dropped.
    task automatic ignore_busy_command();
        fork
            begin
                send_byte(cmd_read_base);
                send_byte(cmd_read_base + 8'd1);
            end
            begin
                expect_byte("tx high byte", {2'd0, 4'b0000, adc_value[0][9:8]}, 400);
                expect_byte("tx low byte", adc_value[0][7:0], 100);
            end
        join
        expect_silence(400);
    endtask

    initial begin
        clk = 1'b0;
        reset_b = 1'b0;
        rx = 1'b1;
        adc_sdata = '0;
        cs_q = 1'b1;
        sclk_q = 1'b0;
        bit_ptr = 0;
        check_errors = 0;
        timeout_errors = 0;
        seed = 32'h2adc_232c;
        foreach (adc_value[i]) adc_value[i] = '0;
        repeat (2) @(negedge clk);
        reset_b = 1'b1;
        @(negedge clk);

        verify_reset_state();
        read_all_channels(10'h2a5, 10'h15a, 10'h3ff, 10'h001);
        read_all_channels(10'h0f0, 10'h30f, 10'h000, 10'h2c3);
        reject_bad_commands();
        random_channel_reads();
        ignore_busy_command();

        $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* tb/adc_uart_properties.sv */
// Concurrent assertions on SPI framing, pulse widths and the UART transmit handshake.
module adc_uart_properties import adc_pkg::*; (
    input logic clk,
    input logic reset_b,
    input logic cs,
    input logic sclk,
    input logic tx_start,
    input logic tx_ready,
    input logic rx_valid,
    input logic frame_done
);

    logic [7:0] cs_low_cnt;

    // counts the sampled cycles of the current chip select low phase.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            cs_low_cnt <= '0;
        end else if (!cs) begin
            cs_low_cnt <= cs_low_cnt + 1'b1;
        end else begin
            cs_low_cnt <= '0;
        end
    end

    sclk_idle_low: assert property (@(posedge clk) disable iff (!reset_b) cs |-> !sclk)
        else $error("sclk is high while cs is high");

    cs_low_length: assert property (@(posedge clk) disable iff (!reset_b)
        $rose(cs) |-> (cs_low_cnt == 8'(spi_frame_bits * 2 * spi_half_period)))
        else $error("cs low phase has the wrong length");

    // the transmitter must also take the byte and go busy on the next cycle.
    tx_start_ready: assert property (@(posedge clk) disable iff (!reset_b)
        tx_start |-> tx_ready ##1 !tx_ready)
        else $error("tx_start while the transmitter is busy or ready did not drop");

    rx_valid_pulse: assert property (@(posedge clk) disable iff (!reset_b)
        rx_valid |=> !rx_valid)
        else $error("rx_valid is longer than one cycle");

    frame_done_pulse: assert property (@(posedge clk) disable iff (!reset_b)
        frame_done |=> !frame_done)
        else $error("frame_done is longer than one cycle");

endmodule

bind adc_uart_top adc_uart_properties i_adc_uart_properties (
    .clk        (clk),
    .reset_b    (reset_b),
    .cs         (cs),
    .sclk       (sclk),
    .tx_start   (tx_start),
    .tx_ready   (tx_ready),
    .rx_valid   (rx_valid),
    .frame_done (frame_done)
);

/* hdl/adc_uart_top.sv */
// Top level of the four-channel ADC readout with SPI capture and UART command interface.
module adc_uart_top import adc_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_b,
    input  logic [num_channels-1:0] adc_sdata,
    output logic                    cs,
    output logic                    sclk,
    input  logic                    rx,
    output logic                    tx
);

    logic                         bit_strobe;
    logic                         frame_done;
    sample_t [num_channels-1:0]   samples;
    sample_bank_t                 bank;
    logic [7:0]                   rx_byte;
    logic                         rx_valid;
    logic [7:0]                   tx_byte;
    logic                         tx_start;
    logic                         tx_ready;

    spi_frame_timer i_spi_frame_timer (
        .clk        (clk),
        .reset_b    (reset_b),
        .cs         (cs),
        .sclk       (sclk),
        .bit_strobe (bit_strobe),
        .frame_done (frame_done)
    );

    // all channels share one chip select and serial clock.
    for (genvar ch = 0; ch < num_channels; ch++) begin : g_capture
        adc_spi_capture i_adc_spi_capture (
            .clk        (clk),
            .reset_b    (reset_b),
            .sdata      (adc_sdata[ch]),
            .bit_strobe (bit_strobe),
            .frame_done (frame_done),
            .sample     (samples[ch])
        );
    end

    // element 0 lands in ch0 at the bottom of the bank.
    assign bank = sample_bank_t'(samples);

    uart_rx i_uart_rx (
        .clk      (clk),
        .reset_b  (reset_b),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    readout_controller i_readout_controller (
        .clk      (clk),
        .reset_b  (reset_b),
        .bank     (bank),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .tx_ready (tx_ready),
        .tx_byte  (tx_byte),
        .tx_start (tx_start)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .reset_b  (reset_b),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (tx),
        .tx_ready (tx_ready)
    );

endmodule

/* hdl/readout_controller.sv */
// Readout controller that decodes host commands and sends the frozen sample as two bytes.
module readout_controller import adc_pkg::*; (
    input  logic         clk,
    input  logic         reset_b,
    input  sample_bank_t bank,
    input  logic [7:0]   rx_byte,
    input  logic         rx_valid,
    input  logic         tx_ready,
    output logic [7:0]   tx_byte,
    output logic         tx_start
);

    typedef enum logic [2:0] {
        idle,
        send_high,
        wait_ready,
        send_low,
        send_error
    } state_t;

    state_t     state;
    reply_t     reply;
    logic [7:0] cmd_offset;
    logic       cmd_valid;
    sample_t    selected;

    // commands below the base wrap to large offsets and fail the range check.
    assign cmd_offset = rx_byte - cmd_read_base;
    assign cmd_valid  = (cmd_offset < 8'(num_channels));

    always_comb begin
        case (cmd_offset[1:0])
            2'd0:    selected = bank.ch0;
            2'd1:    selected = bank.ch1;
            2'd2:    selected = bank.ch2;
            default: selected = bank.ch3;
        endcase
    end

    // commands are only taken in idle, so a busy controller drops them.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (rx_valid) state <= cmd_valid ? send_high : send_error;
                end
                send_high: begin
                    if (tx_ready) state <= wait_ready;
                end
                wait_ready: begin
                    // the transmitter is busy with the high byte until ready returns.
                    if (tx_ready) state <= send_low;
                end
                send_low: begin
                    if (tx_ready) state <= idle;
                end
                send_error: begin
                    if (tx_ready) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // freeze the sample so a new frame cannot split the reply.
    always_ff @(posedge clk) begin
        if (state == idle && rx_valid && cmd_valid) begin
            reply.channel <= cmd_offset[1:0];
            reply.value   <= selected;
        end
    end

    always_comb begin
        tx_start = 1'b0;
        tx_byte  = reply_error;
        case (state)
            send_high: begin
                tx_start = tx_ready;
                tx_byte  = {reply.channel, 4'b0000, reply.value[sample_width-1 -: 2]};
            end
            send_low: begin
                tx_start = tx_ready;
                tx_byte  = reply.value[7:0];
            end
            send_error: begin
                tx_start = tx_ready;
            end
            default: tx_start = 1'b0;
        endcase
    end

endmodule

/* hdl/uart_tx.sv */
// 8N1 UART transmitter with a start strobe and an idle ready level.
module uart_tx import adc_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  logic [7:0] tx_byte,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_ready
);

    logic                            busy;
    logic [$clog2(clks_per_bit)-1:0] clk_cnt;
    logic [3:0]                      bit_cnt;
    logic [8:0]                      frame;
    logic                            load;
    logic                            bit_end;
    logic                            shift_tick;

    assign tx_ready   = !busy;
    assign load       = tx_start && !busy;
    assign bit_end    = busy && (clk_cnt == clks_per_bit - 1);
    // bit_cnt 0 is the start bit and 9 the stop bit.
    assign shift_tick = bit_end && (bit_cnt != 4'd9);

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else if (load) begin
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b0;
        end else if (busy) begin
            if (bit_end) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) begin
                    busy <= 1'b0;
                end else begin
                    tx      <= frame[0];
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // the stop bit rides above the data and ones fill in behind it.
    always_ff @(posedge clk) begin
        if (load) begin
            frame <= {1'b1, tx_byte};
        end else if (shift_tick) begin
            frame <= {1'b1, frame[8:1]};
        end
    end

endmodule

/* hdl/uart_rx.sv */
// 8N1 UART receiver with input synchronizer, mid-bit sampling and a byte strobe.
module uart_rx import adc_pkg::*; (
    input  logic       clk,
    input  logic       reset_b,
    input  logic       rx,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t                       state;
    logic                            rx_meta;
    logic                            rx_s;
    logic [$clog2(clks_per_bit)-1:0] clk_cnt;
    logic [2:0]                      bit_idx;
    logic [7:0]                      shift_reg;
    logic                            bit_end;
    logic                            data_tick;
    logic                            stop_tick;

    assign bit_end   = (clk_cnt == clks_per_bit - 1);
    assign data_tick = (state == rx_data) && bit_end;
    assign stop_tick = (state == rx_stop) && bit_end;

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            state    <= rx_idle;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= clk_cnt + 1'b1;
            case (state)
                rx_idle: begin
                    clk_cnt <= '0;
                    if (!rx_s) state <= rx_start;
                end
                rx_start: begin
                    // recheck in the middle of the start bit to reject glitches.
                    if (clk_cnt == clks_per_bit / 2 - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? rx_idle : rx_data;
                    end
                end
                rx_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= rx_stop;
                    end
                end
                rx_stop: begin
                    // a low stop bit means a framing error, and the byte is dropped.
                    if (bit_end) begin
                        rx_valid <= rx_s;
                        state    <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data arrives LSB first.
    always_ff @(posedge clk) begin
        if (data_tick) shift_reg <= {rx_s, shift_reg[7:1]};
        if (stop_tick && rx_s) rx_byte <= shift_reg;
    end

endmodule

/* hdl/adc_spi_capture.sv */
// Per-channel SPI capture that shifts the data line and keeps the latest 10-bit sample.
module adc_spi_capture import adc_pkg::*; (
    input  logic    clk,
    input  logic    reset_b,
    input  logic    sdata,
    input  logic    bit_strobe,
    input  logic    frame_done,
    output sample_t sample
);

    logic [spi_frame_bits-1:0] shift_reg;

    // the first frame bit ends up in the MSB after a full frame.
    always_ff @(posedge clk) begin
        if (bit_strobe) begin
            shift_reg <= {shift_reg[spi_frame_bits-2:0], sdata};
        end
    end

    // the sample field sits below the leading zeros, the two trailing bits are dropped.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            sample <= '0;
        end else if (frame_done) begin
            sample <= shift_reg[spi_frame_bits-spi_lead_bits-1 -: sample_width];
        end
    end

endmodule

/* hdl/spi_frame_timer.sv */
// SPI frame timer producing chip select, serial clock, bit strobe and frame end pulse.
module spi_frame_timer import adc_pkg::*; (
    input  logic clk,
    input  logic reset_b,
    output logic cs,
    output logic sclk,
    output logic bit_strobe,
    output logic frame_done
);

    logic                               in_gap;
    logic [$clog2(spi_gap_cycles)-1:0]  gap_cnt;
    logic [$clog2(spi_half_period)-1:0] half_cnt;
    logic [$clog2(spi_frame_bits)-1:0]  bit_cnt;

    // a frame is a gap with cs high followed by 16 serial clock periods with cs low.
    always_ff @(posedge clk or negedge reset_b) begin
        if (!reset_b) begin
            in_gap     <= 1'b1;
            gap_cnt    <= '0;
            half_cnt   <= '0;
            bit_cnt    <= '0;
            cs         <= 1'b1;
            sclk       <= 1'b0;
            bit_strobe <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            bit_strobe <= 1'b0;
            frame_done <= 1'b0;
            if (in_gap) begin
                if (gap_cnt == spi_gap_cycles - 1) begin
                    gap_cnt <= '0;
                    in_gap  <= 1'b0;
                    cs      <= 1'b0;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end else if (half_cnt == spi_half_period - 1) begin
                half_cnt <= '0;
                sclk     <= ~sclk;
                if (!sclk) begin
                    // rising edge of the serial clock.
                    bit_strobe <= 1'b1;
                end else if (bit_cnt == spi_frame_bits - 1) begin
                    // last falling edge, so sclk and cs change together.
                    bit_cnt    <= '0;
                    in_gap     <= 1'b1;
                    cs         <= 1'b1;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/adc_pkg.sv */
// Shared rate constants, command codes and the sample and reply types of the ADC readout.
package adc_pkg;

    // sample format of the serial ADCs.
    localparam int sample_width = 10;
    localparam int num_channels = 4;

    // SPI frame timing, in clk cycles and serial clock periods.
    localparam int spi_half_period = 4;
    localparam int spi_frame_bits = 16;
    localparam int spi_gap_cycles = 16;

    // frame bits 4 to 13 carry the sample MSB first.
    localparam int spi_lead_bits = 4;

    // UART bit period in clk cycles.
    localparam int clks_per_bit = 16;

    // 'A' to 'D' read channels 0 to 3, anything else gets '?'.
    localparam logic [7:0] cmd_read_base = 8'h41;
    localparam logic [7:0] reply_error = 8'h3f;

    typedef logic [sample_width-1:0] sample_t;

    // latest sample of every channel, ch0 in the low bits.
    typedef struct packed {
        sample_t ch3;
        sample_t ch2;
        sample_t ch1;
        sample_t ch0;
    } sample_bank_t;

    // frozen answer to one read command.
    typedef struct packed {
        logic [1:0] channel;
        sample_t    value;
    } reply_t;

endpackage
